/* vlog.f */
+incdir+tb
common/core_pkg.sv
source/pc_fetch.sv
decode/decoder.sv
decode/reg_file.sv
execute/alu_stage.sv
source/mips_core.sv
tb/core_tb.sv

/* Bender.yml */
package:
  name: mips_core

sources:
  - common/core_pkg.sv
  - source/pc_fetch.sv
  - decode/decoder.sv
  - decode/reg_file.sv
  - execute/alu_stage.sv
  - source/mips_core.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/core_tb.sv

/* tb/core_tb_tasks.svh */
task automatic check_wb(wb_t exp, wb_t act);
  if (act.addr !== exp.addr) begin
    $display("FAIL debug_wb_o.addr: expected %h, got %h", exp.addr, act.addr);
    errors++;
  end
  if (act.data !== exp.data) begin
    $display("FAIL debug_wb_o.data: expected %h, got %h", exp.data, act.data);
    errors++;
  end
  if (act.pc !== exp.pc) begin
    $display("FAIL debug_wb_o.pc: expected %h, got %h", exp.pc, act.pc);
    errors++;
  end
endtask

task automatic check_count(int exp_n, int act_n);
  if (act_n < exp_n) begin
    $display("%0d register writes are missing", exp_n - act_n);
    errors++;
  end else if (act_n > exp_n) begin
    $display("%0d register writes came that were not expected", act_n - exp_n);
    errors++;
  end
endtask

task automatic check_addr(addr_t exp, addr_t act);
  if (act !== exp) begin
    $display("FAIL rom_addr_o: expected %h, got %h", exp, act);
    errors++;
  end
endtask

task automatic reset_test();
  prog = '{itype(OP_LUI, 1, 0, 16'h1234),
           itype(OP_ORI, 1, 1, 16'h5678),
           itype(OP_ADDIU, 2, 1, 16'h0001)};
  run_program("reset", 0, 0, 3);
endtask

task automatic immediate_test();
  prog = '{itype(OP_LUI, 1, 0, 16'hdead),
           itype(OP_ORI, 1, 1, 16'hbeef),
           itype(OP_ADDIU, 2, 1, 16'hffff),
           itype(OP_ADDIU, 3, 0, 16'h7fff),
           itype(OP_ORI, 4, 0, 16'h8000),
           itype(OP_ADDIU, 5, 4, 16'h8000),
           itype(OP_LUI, 6, 0, 16'h0001)};
  run_program("immediates", 0, 0, -1);
endtask

task automatic forward_test();
  data_t v;
  prog.delete();
  for (int r = 1; r <= 4; r++) begin
    v = lcg_next();
    prog.push_back(itype(OP_LUI, r, 0, v[31:16]));
    prog.push_back(itype(OP_ORI, r, r, v[15:0]));
  end
  prog.push_back(rtype(F_ADDU, 5, 1, 2, 0));
  prog.push_back(rtype(F_SUBU, 6, 5, 3, 0));
  prog.push_back(rtype(F_AND, 7, 6, 5, 0));
  prog.push_back(rtype(F_OR, 8, 7, 4, 0));
  prog.push_back(rtype(F_XOR, 9, 8, 6, 0));
  run_program("forwarding", 0, 0, -1);
endtask

task automatic shift_test();
  prog = '{itype(OP_LUI, 1, 0, 16'h8000),
           itype(OP_ORI, 1, 1, 16'h00f1),
           rtype(F_SLL, 2, 0, 1, 4),
           rtype(F_SRL, 3, 0, 1, 31),
           rtype(F_SLL, 4, 0, 1, 0),
           rtype(F_SRL, 5, 0, 1, 7),
           itype(OP_ADDIU, 6, 0, 16'hfffd),
           rtype(F_SLT, 7, 6, 0, 0),
           rtype(F_SLT, 8, 1, 6, 0),
           rtype(F_SLT, 9, 6, 1, 0),
           rtype(F_SLT, 10, 0, 6, 0)};
  run_program("shifts and compares", 0, 0, -1);
endtask

// Opcode 3f and funct 3f are both undefined
task automatic zero_test();
  prog = '{itype(OP_ADDIU, 0, 0, 16'h0005),
           rtype(F_ADDU, 0, 1, 1, 0),
           itype(OP_ADDIU, 1, 0, 16'h0007),
           32'hfc23_0009,
           32'h0022_183f,
           rtype(F_ADDU, 2, 0, 1, 0),
           rtype(F_OR, 3, 0, 0, 0)};
  run_program("register zero and unknown opcodes", 0, 0, -1);
endtask

task automatic stall_test();
  prog = '{itype(OP_ADDIU, 1, 0, 16'h0003),
           rtype(F_ADDU, 2, 1, 1, 0),
           rtype(F_ADDU, 3, 2, 1, 0),
           rtype(F_SUBU, 4, 3, 2, 0),
           rtype(F_XOR, 5, 4, 3, 0),
           rtype(F_SLL, 6, 0, 5, 2),
           rtype(F_OR, 7, 6, 1, 0)};
  run_program("stall", 4, 5, -1);
endtask

/* tb/core_tb.sv */
`timescale 1ns/1ps

module core_tb;
  import core_pkg::*;

  localparam addr_t BOOT_PC   = 32'hbfc0_0000;
  localparam int    ROM_WORDS = 64;
  localparam int    MARGIN    = 20;

  logic  clk;
  logic  reset_i;
  logic  stall_i;
  addr_t rom_addr;
  addr_t rom_index;
  inst_t rom_data;
  wb_t   debug_wb;

  inst_t       rom [ROM_WORDS];
  inst_t       prog [$];
  wb_t         exp_q [$];
  wb_t         obs_q [$];
  logic [31:0] lcg_state;
  int          errors;
  int          tests_passed;
  int          tests_failed;
  int          cycles;
  int          cycle_limit;
  int          run_cycle;
  int          first_wb_cycle;

  mips_core uut (
    .clk             (clk),
    .reset_i         (reset_i),
    .stall_i         (stall_i),
    .rom_addr_o      (rom_addr),
    .rom_read_data_i (rom_data),
    .debug_wb_o      (debug_wb)
  );

  // Combinational ROM, zero past the program
  assign rom_index = (rom_addr - BOOT_PC) >> 2;
  assign rom_data  = (rom_index < ROM_WORDS) ? rom[rom_index] : '0;

  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  // Writes are taken at the edge that commits them
  always @(posedge clk) begin
    cycles++;
    if (debug_wb.en) begin
      obs_q.push_back(debug_wb);
      if (first_wb_cycle < 0 && !reset_i) begin
        first_wb_cycle = run_cycle;
      end
      if (stall_i) begin
        $display("Write to r%0d appeared while the core was stalled", debug_wb.addr);
        errors++;
      end
    end
    if (!reset_i) begin
      run_cycle++;
    end
    if (cycles > cycle_limit) begin
      $display("Timeout, the tests did not finish within %0d cycles", cycle_limit);
      $display("Test failed");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic inst_t rtype(funct_e funct, int rd, int rs, int rt, int sh);
    return {OP_SPECIAL, 5'(rs), 5'(rt), 5'(rd), 5'(sh), funct};
  endfunction

  function automatic inst_t itype(opcode_e op, int rt, int rs, logic [15:0] imm);
    return {op, 5'(rs), 5'(rt), imm};
  endfunction

  // Sequential ISA model, one instruction at a time
  task automatic build_expected();
    data_t     regs [32];
    inst_t     inst;
    data_t     rs_v;
    data_t     rt_v;
    data_t     val;
    reg_addr_t dest;
    logic      writes;
    wb_t       rec;
    for (int r = 0; r < 32; r++) begin
      regs[r] = '0;
    end
    exp_q.delete();
    for (int i = 0; i < prog.size(); i++) begin
      inst   = prog[i];
      rs_v   = regs[inst[25:21]];
      rt_v   = regs[inst[20:16]];
      dest   = inst[20:16];
      writes = 1'b1;
      val    = '0;
      case (inst[31:26])
        6'h00: begin
          dest = inst[15:11];
          case (inst[5:0])
            6'h00:   val = rt_v << inst[10:6];
            6'h02:   val = rt_v >> inst[10:6];
            6'h21:   val = rs_v + rt_v;
            6'h23:   val = rs_v - rt_v;
            6'h24:   val = rs_v & rt_v;
            6'h25:   val = rs_v | rt_v;
            6'h26:   val = rs_v ^ rt_v;
            6'h2a:   val = ($signed(rs_v) < $signed(rt_v)) ? 32'd1 : 32'd0;
            default: writes = 1'b0;
          endcase
        end
        6'h09:   val = rs_v + {{16{inst[15]}}, inst[15:0]};
        6'h0d:   val = rs_v | {16'h0000, inst[15:0]};
        6'h0f:   val = {inst[15:0], 16'h0000};
        default: writes = 1'b0;
      endcase
      if (writes && dest != 5'd0) begin
        regs[dest] = val;
        rec.en     = 1'b1;
        rec.addr   = dest;
        rec.data   = val;
        rec.pc     = BOOT_PC + addr_t'(4 * i);
        exp_q.push_back(rec);
      end
    end
  endtask

  task automatic reset_core();
    @(negedge clk);
    reset_i = 1'b1;
    stall_i = 1'b0;
    obs_q.delete();
    repeat (2) begin
      @(negedge clk);
      check_addr(BOOT_PC, rom_addr);
    end
    reset_i        = 1'b0;
    run_cycle      = 0;
    first_wb_cycle = -1;
  endtask

  task automatic run_program(string name, int stall_at, int stall_len, int first_cycle);
    int    start_errors;
    addr_t end_addr;
    start_errors = errors;
    for (int i = 0; i < ROM_WORDS; i++) begin
      rom[i] = (i < prog.size()) ? prog[i] : '0;
    end
    build_expected();
    cycle_limit += prog.size() + 3 + stall_len + MARGIN;
    end_addr = BOOT_PC + addr_t'(4 * (prog.size() + 3));
    reset_core();
    if (stall_len > 0) begin
      repeat (stall_at) @(negedge clk);
      stall_i = 1'b1;
      repeat (stall_len) @(negedge clk);
      stall_i = 1'b0;
    end
    // Pc three words past the end means the last instruction has written
    while (rom_addr !== end_addr) begin
      @(negedge clk);
    end
    check_count(exp_q.size(), obs_q.size());
    for (int i = 0; i < exp_q.size() && i < obs_q.size(); i++) begin
      check_wb(exp_q[i], obs_q[i]);
    end
    if (first_cycle >= 0 && first_wb_cycle != first_cycle) begin
      $display("First write came in cycle %0d after reset instead of cycle %0d",
               first_wb_cycle, first_cycle);
      errors++;
    end
    if (errors == start_errors) begin
      $display("%s: passed with %0d writes", name, obs_q.size());
      tests_passed++;
    end else begin
      $display("%s: failed with %0d errors", name, errors - start_errors);
      tests_failed++;
    end
  endtask

  `include "core_tb_tasks.svh"

  initial begin
    reset_i        = 1'b1;
    stall_i        = 1'b0;
    errors         = 0;
    tests_passed   = 0;
    tests_failed   = 0;
    cycles         = 0;
    cycle_limit    = 0;
    run_cycle      = 0;
    first_wb_cycle = -1;
    lcg_state      = 32'h9c21;
    reset_test();
    immediate_test();
    forward_test();
    shift_test();
    zero_test();
    stall_test();
    $display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* source/mips_core.sv */
`timescale 1ns/1ps

module mips_core #(
  parameter core_pkg::addr_t RESET_PC = 32'hbfc0_0000
) (
  input  logic            clk,
  input  logic            reset_i,
  input  logic            stall_i,
  output core_pkg::addr_t rom_addr_o,
  input  core_pkg::inst_t rom_read_data_i,
  output core_pkg::wb_t   debug_wb_o
);
  import core_pkg::*;

  fetch_t    fetch;
  ex_req_t   ex_req;
  wb_t       ex_fwd;
  wb_t       wb;
  reg_addr_t rs_addr;
  reg_addr_t rt_addr;
  data_t     rs_data;
  data_t     rt_data;

  pc_fetch #(
    .RESET_PC (RESET_PC)
  ) u_pc_fetch (
    .clk             (clk),
    .reset_i         (reset_i),
    .stall_i         (stall_i),
    .rom_addr_o      (rom_addr_o),
    .rom_read_data_i (rom_read_data_i),
    .fetch_o         (fetch)
  );

  decoder u_decoder (
    .clk       (clk),
    .reset_i   (reset_i),
    .stall_i   (stall_i),
    .fetch_i   (fetch),
    .rs_addr_o (rs_addr),
    .rt_addr_o (rt_addr),
    .rs_data_i (rs_data),
    .rt_data_i (rt_data),
    .ex_fwd_i  (ex_fwd),
    .wb_i      (wb),
    .ex_req_o  (ex_req)
  );

  reg_file u_reg_file (
    .clk       (clk),
    .reset_i   (reset_i),
    .rs_addr_i (rs_addr),
    .rt_addr_i (rt_addr),
    .rs_data_o (rs_data),
    .rt_data_o (rt_data),
    .wb_i      (wb)
  );

  alu_stage u_alu_stage (
    .clk      (clk),
    .reset_i  (reset_i),
    .stall_i  (stall_i),
    .ex_req_i (ex_req),
    .ex_fwd_o (ex_fwd),
    .wb_o     (wb)
  );

  assign debug_wb_o = wb;

endmodule

/* execute/alu_stage.sv */
`timescale 1ns/1ps

module alu_stage (
  input  logic              clk,
  input  logic              reset_i,
  input  logic              stall_i,
  input  core_pkg::ex_req_t ex_req_i,
  output core_pkg::wb_t     ex_fwd_o,
  output core_pkg::wb_t     wb_o
);
  import core_pkg::*;

  data_t result;
  wb_t   wb_q;

  always_comb begin
    case (ex_req_i.alu_op)
      ALU_ADD: result = ex_req_i.operand_a + ex_req_i.operand_b;
      ALU_SUB: result = ex_req_i.operand_a - ex_req_i.operand_b;
      ALU_AND: result = ex_req_i.operand_a & ex_req_i.operand_b;
      ALU_OR:  result = ex_req_i.operand_a | ex_req_i.operand_b;
      ALU_XOR: result = ex_req_i.operand_a ^ ex_req_i.operand_b;
      // Signed compare
      ALU_SLT: begin
        result = {{(DATA_W-1){1'b0}},
                  $signed(ex_req_i.operand_a) < $signed(ex_req_i.operand_b)};
      end
      ALU_SLL: result = ex_req_i.operand_b << ex_req_i.shamt;
      ALU_SRL: result = ex_req_i.operand_b >> ex_req_i.shamt;
      default: result = '0;
    endcase
  end

  // Result of the op now in execute, seen by decode
  always_comb begin
    ex_fwd_o.en   = ex_req_i.wb_en;
    ex_fwd_o.addr = ex_req_i.wb_addr;
    ex_fwd_o.data = result;
    ex_fwd_o.pc   = ex_req_i.pc;
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      wb_q.en <= 1'b0;
    end else if (!stall_i) begin
      wb_q <= ex_fwd_o;
    end
  end

  // Held record shows up once the stall drops
  always_comb begin
    wb_o    = wb_q;
    wb_o.en = wb_q.en & ~stall_i;
  end

endmodule

/* decode/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
  input  logic                clk,
  input  logic                reset_i,
  input  core_pkg::reg_addr_t rs_addr_i,
  input  core_pkg::reg_addr_t rt_addr_i,
  output core_pkg::data_t     rs_data_o,
  output core_pkg::data_t     rt_data_o,
  input  core_pkg::wb_t       wb_i
);
  import core_pkg::*;

  localparam int NUM_REGS = 2**REG_ADDR_W;

  data_t regs [NUM_REGS];

  // Enable already low during stall
  always_ff @(posedge clk) begin
    if (reset_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_i.en) begin
      regs[wb_i.addr] <= wb_i.data;
    end
  end

  assign rs_data_o = (rs_addr_i == '0) ? '0 : regs[rs_addr_i];
  assign rt_data_o = (rt_addr_i == '0) ? '0 : regs[rt_addr_i];

  a_r0_untouched : assert property (
    @(posedge clk) disable iff (reset_i) wb_i.en |-> wb_i.addr != '0
  );

endmodule

/* decode/decoder.sv */
`timescale 1ns/1ps

module decoder (
  input  logic                clk,
  input  logic                reset_i,
  input  logic                stall_i,
  input  core_pkg::fetch_t    fetch_i,
  output core_pkg::reg_addr_t rs_addr_o,
  output core_pkg::reg_addr_t rt_addr_o,
  input  core_pkg::data_t     rs_data_i,
  input  core_pkg::data_t     rt_data_i,
  input  core_pkg::wb_t       ex_fwd_i,
  input  core_pkg::wb_t       wb_i,
  output core_pkg::ex_req_t   ex_req_o
);
  import core_pkg::*;

  opcode_e     opcode;
  funct_e      funct;
  reg_addr_t   rs_addr;
  reg_addr_t   rt_addr;
  reg_addr_t   rd_addr;
  logic [15:0] imm;
  data_t       rs_val;
  data_t       rt_val;
  ex_req_t     req;

  // Youngest producer wins, r0 is always zero
  function automatic data_t forward(reg_addr_t addr, data_t rf_data, wb_t ex_fwd, wb_t wb);
    if (addr == '0) begin
      return '0;
    end
    if (ex_fwd.en && ex_fwd.addr == addr) begin
      return ex_fwd.data;
    end
    if (wb.en && wb.addr == addr) begin
      return wb.data;
    end
    return rf_data;
  endfunction

  assign opcode  = opcode_e'(fetch_i.inst[31:26]);
  assign funct   = funct_e'(fetch_i.inst[5:0]);
  assign rs_addr = fetch_i.inst[25:21];
  assign rt_addr = fetch_i.inst[20:16];
  assign rd_addr = fetch_i.inst[15:11];
  assign imm     = fetch_i.inst[15:0];

  assign rs_addr_o = rs_addr;
  assign rt_addr_o = rt_addr;

  assign rs_val = forward(rs_addr, rs_data_i, ex_fwd_i, wb_i);
  assign rt_val = forward(rt_addr, rt_data_i, ex_fwd_i, wb_i);

  always_comb begin
    req.alu_op    = ALU_NOP;
    req.operand_a = rs_val;
    req.operand_b = rt_val;
    req.shamt     = fetch_i.inst[10:6];
    req.wb_addr   = rd_addr;
    req.pc        = fetch_i.pc;
    case (opcode)
      OP_SPECIAL: begin
        case (funct)
          F_SLL:   req.alu_op = ALU_SLL;
          F_SRL:   req.alu_op = ALU_SRL;
          F_ADDU:  req.alu_op = ALU_ADD;
          F_SUBU:  req.alu_op = ALU_SUB;
          F_AND:   req.alu_op = ALU_AND;
          F_OR:    req.alu_op = ALU_OR;
          F_XOR:   req.alu_op = ALU_XOR;
          F_SLT:   req.alu_op = ALU_SLT;
          default: req.alu_op = ALU_NOP;
        endcase
      end
      OP_ADDIU: begin
        req.alu_op    = ALU_ADD;
        req.operand_b = {{(DATA_W-16){imm[15]}}, imm};
        req.wb_addr   = rt_addr;
      end
      OP_ORI: begin
        req.alu_op    = ALU_OR;
        req.operand_b = {{(DATA_W-16){1'b0}}, imm};
        req.wb_addr   = rt_addr;
      end
      // lui as an OR with zero
      OP_LUI: begin
        req.alu_op    = ALU_OR;
        req.operand_a = '0;
        req.operand_b = {imm, {(DATA_W-16){1'b0}}};
        req.wb_addr   = rt_addr;
      end
      default: req.alu_op = ALU_NOP;
    endcase
    req.wb_en = (req.alu_op != ALU_NOP) && (req.wb_addr != '0);
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      ex_req_o.alu_op <= ALU_NOP;
      ex_req_o.wb_en  <= 1'b0;
    end else if (!stall_i) begin
      ex_req_o <= req;
    end
  end

  a_no_r0_write : assert property (
    @(posedge clk) disable iff (reset_i) ex_req_o.wb_en |-> ex_req_o.wb_addr != '0
  );

endmodule

/* source/pc_fetch.sv */
`timescale 1ns/1ps

module pc_fetch #(
  parameter core_pkg::addr_t RESET_PC = 32'hbfc0_0000
) (
  input  logic             clk,
  input  logic             reset_i,
  input  logic             stall_i,
  output core_pkg::addr_t  rom_addr_o,
  input  core_pkg::inst_t  rom_read_data_i,
  output core_pkg::fetch_t fetch_o
);
  import core_pkg::*;

  addr_t pc;

  // Program counter, steps one word per cycle
  always_ff @(posedge clk) begin
    if (reset_i) begin
      pc <= RESET_PC;
    end else if (!stall_i) begin
      pc <= pc + addr_t'(4);
    end
  end

  assign rom_addr_o = pc;

  // Zero word is sll r0, so nothing is written
  always_ff @(posedge clk) begin
    if (reset_i) begin
      fetch_o.inst <= '0;
    end else if (!stall_i) begin
      fetch_o.pc   <= pc;
      fetch_o.inst <= rom_read_data_i;
    end
  end

  a_pc_aligned : assert property (
    @(posedge clk) disable iff (reset_i) rom_addr_o[1:0] == 2'b00
  );

endmodule

/* common/core_pkg.sv */
package core_pkg;

  localparam int DATA_W     = 32;
  localparam int REG_ADDR_W = 5;

  typedef logic [DATA_W-1:0]     data_t;
  typedef logic [DATA_W-1:0]     addr_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [31:0]           inst_t;

  // Major opcode field
  typedef enum logic [5:0] {
    OP_SPECIAL = 6'h00,
    OP_ADDIU   = 6'h09,
    OP_ORI     = 6'h0d,
    OP_LUI     = 6'h0f
  } opcode_e;

  // Function field of SPECIAL
  typedef enum logic [5:0] {
    F_SLL  = 6'h00,
    F_SRL  = 6'h02,
    F_ADDU = 6'h21,
    F_SUBU = 6'h23,
    F_AND  = 6'h24,
    F_OR   = 6'h25,
    F_XOR  = 6'h26,
    F_SLT  = 6'h2a
  } funct_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLL,
    ALU_SRL,
    ALU_NOP
  } alu_op_e;

  typedef struct packed {
    addr_t pc;
    inst_t inst;
  } fetch_t;

  typedef struct packed {
    alu_op_e    alu_op;
    data_t      operand_a;
    data_t      operand_b;
    logic [4:0] shamt;
    logic       wb_en;
    reg_addr_t  wb_addr;
    addr_t      pc;
  } ex_req_t;

  typedef struct packed {
    logic      en;
    reg_addr_t addr;
    data_t     data;
    addr_t     pc;
  } wb_t;

endpackage
